// File: src/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry
`define ICACHE_WAYS 2
`define ICACHE_SETS 128

// 32-bit words per block, moved as 64-bit beats
`define ICACHE_BLOCK_WORDS 8

// top nibble of the uncached address region
`define ICACHE_UNCACHED_BASE 4'hA

// fetch address error
`define ICACHE_ECODE_ADEF 6'h08

`endif

// File: src/icache_pkg.sv
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

    localparam int unsigned BEATS   = `ICACHE_BLOCK_WORDS / 2;
    localparam int unsigned BEAT_W  = $clog2(BEATS);
    localparam int unsigned INDEX_W = $clog2(`ICACHE_SETS);
    localparam int unsigned TAG_W   = 32 - INDEX_W - BEAT_W - 3;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [BEAT_W-1:0]  beat;
        logic               word;
        logic [1:0]         byte_off;
    } fetch_view_t;

    // cacop address, way picked by bit 0
    typedef struct packed {
        logic [TAG_W-1:0]   upper;
        logic [INDEX_W-1:0] index;
        logic [BEAT_W+1:0]  unused;
        logic               way;
    } maint_view_t;

    typedef union packed {
        fetch_view_t fetch;
        maint_view_t maint;
    } fetch_addr_u;

    typedef struct packed {
        fetch_addr_u pc;
        logic [1:0]  mask;
        logic        uncached;
        logic        misaligned;
    } fetch_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tag_entry_t;

    typedef struct packed {
        logic [`ICACHE_WAYS-1:0] tag_we;
        logic [`ICACHE_WAYS-1:0] data_we;
        logic [INDEX_W-1:0]      index;
        logic [BEAT_W-1:0]       beat;
        tag_entry_t              entry;
        logic [63:0]             data;
    } array_wr_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [1:0]  mask;
        logic [63:0] insts;
        logic        exc;
        logic [5:0]  ecode;
    } inst_pkt_t;

endpackage

`default_nettype wire

// File: src/fetch_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module fetch_decode (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          fetch_valid_i,
    input  logic [31:0]                   fetch_pc_i,
    input  logic [1:0]                    fetch_mask_i,
    input  logic                          inst_ready_i,
    input  logic                          stall_i,
    output logic                          fetch_ready_o,
    output icache_pkg::fetch_req_t        req_o,
    output logic [icache_pkg::INDEX_W-1:0] rd_index_o,
    output logic                          req_valid_o
);

    import icache_pkg::*;

    fetch_addr_u pc_in;
    fetch_req_t  req_q;
    logic        valid_q;
    logic        accept;

    assign pc_in = fetch_pc_i;

    // a held packet blocks until decode takes it
    assign fetch_ready_o = !stall_i && (!valid_q || inst_ready_i);
    assign accept        = fetch_valid_i && fetch_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (fetch_ready_o) begin
            valid_q <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.pc         <= pc_in;
            req_q.mask       <= fetch_mask_i;
            req_q.uncached   <= (pc_in[31:28] == `ICACHE_UNCACHED_BASE);
            req_q.misaligned <= |pc_in.fetch.byte_off;
        end
    end

    // arrays see the new index on accept, else keep reading the held one
    assign rd_index_o = accept ? pc_in.fetch.index : req_q.pc.fetch.index;

    assign req_o       = req_q;
    assign req_valid_o = valid_q;

endmodule

`default_nettype wire

// File: src/cache_ways.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module cache_ways (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [icache_pkg::INDEX_W-1:0]             rd_index_i,
    input  logic [icache_pkg::BEAT_W-1:0]              rd_beat_i,
    input  icache_pkg::array_wr_t                      wr_i,
    output icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0]  tags_o,
    output logic [`ICACHE_WAYS-1:0][63:0]              beats_o
);

    import icache_pkg::*;

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic [TAG_W-1:0]           tag_mem [`ICACHE_SETS];
        logic [BEATS-1:0][63:0]     data_mem [`ICACHE_SETS];
        logic [`ICACHE_SETS-1:0]    valid_q;
        logic [TAG_W-1:0]           tag_rd_q;
        logic                       valid_rd_q;
        logic [BEATS-1:0][63:0]     row_rd_q;

        // tag and data storage, read one cycle after the index
        always_ff @(posedge clk) begin
            if (wr_i.tag_we[w]) begin
                tag_mem[wr_i.index] <= wr_i.entry.tag;
            end
            if (wr_i.data_we[w]) begin
                data_mem[wr_i.index][wr_i.beat] <= wr_i.data;
            end
            tag_rd_q <= tag_mem[rd_index_i];
            row_rd_q <= data_mem[rd_index_i];
        end

        // valid bits live in flops so reset can clear them
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                valid_q    <= '0;
                valid_rd_q <= 1'b0;
            end else begin
                if (wr_i.tag_we[w]) begin
                    valid_q[wr_i.index] <= wr_i.entry.valid;
                end
                valid_rd_q <= valid_q[rd_index_i];
            end
        end

        assign tags_o[w].tag   = tag_rd_q;
        assign tags_o[w].valid = valid_rd_q;

        // beat picked by the registered request
        assign beats_o[w] = row_rd_q[rd_beat_i];
    end

endmodule

`default_nettype wire

// File: src/refill_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module refill_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  icache_pkg::fetch_req_t req_i,
    input  logic                   req_valid_i,
    input  logic                   hit_i,
    input  logic                   inst_ready_i,
    input  logic                   cacop_valid_i,
    input  logic [1:0]             cacop_op_i,
    input  logic [31:0]            cacop_addr_i,
    input  logic                   mem_resp_ready_i,
    input  logic                   mem_data_valid_i,
    input  logic [31:0]            mem_data_i,
    output logic                   stall_o,
    output icache_pkg::array_wr_t  wr_o,
    output logic [63:0]            unc_data_o,
    output logic                   unc_done_o,
    output logic                   cacop_ready_o,
    output logic                   cacop_done_o,
    output logic                   mem_addr_valid_o,
    output logic [31:0]            mem_addr_o,
    output logic [7:0]             mem_len_o
);

    import icache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_MISS_REQ,
        S_MISS_DATA,
        S_REPLAY,
        S_UNC_REQ,
        S_UNC_DATA
    } state_e;

    state_e                  state_q;
    state_e                  state_d;
    logic [3:0]              cnt_q;
    logic [31:0]             lo_q;
    logic [1:0][31:0]        unc_q;
    logic [`ICACHE_SETS-1:0] repl_q;
    fetch_addr_u             cacop_addr;
    logic                    active;
    logic                    need_refill;
    logic                    need_unc;
    logic                    unc_first;
    logic                    unc_lane;
    logic                    unc_full;
    logic [3:0]              unc_len;
    logic                    last_word;
    logic [`ICACHE_WAYS-1:0] way_oh;

    assign cacop_addr  = cacop_addr_i;
    assign active      = req_valid_i && |req_i.mask && !req_i.misaligned;
    assign need_refill = active && !req_i.uncached && !hit_i;
    assign need_unc    = active && req_i.uncached;

    // uncached lanes, mask 10 starts at the upper word
    assign unc_len   = (req_i.mask == 2'b11) ? 4'd2 : 4'd1;
    assign unc_first = (req_i.mask == 2'b10);
    assign unc_lane  = unc_first ^ cnt_q[0];
    assign unc_full  = (cnt_q == unc_len);
    assign last_word = (cnt_q == 4'(`ICACHE_BLOCK_WORDS - 1));
    assign way_oh    = `ICACHE_WAYS'(1) << repl_q[req_i.pc.fetch.index];

    // request fields are held by the stage while the FSM is busy
    assign mem_addr_o = req_i.uncached
                      ? ({req_i.pc[31:3], 3'b000} + (unc_first ? 32'd4 : 32'd0))
                      : {req_i.pc.fetch.tag, req_i.pc.fetch.index, {(BEAT_W + 3){1'b0}}};
    assign mem_len_o  = req_i.uncached ? {4'd0, unc_len} : 8'(`ICACHE_BLOCK_WORDS);

    assign unc_data_o    = unc_q;
    assign cacop_ready_o = (state_q == S_IDLE);
    assign cacop_done_o  = cacop_valid_i && cacop_ready_o;

    always_comb begin
        state_d          = state_q;
        stall_o          = 1'b0;
        mem_addr_valid_o = 1'b0;
        unc_done_o       = 1'b0;
        wr_o             = '0;
        wr_o.index       = req_i.pc.fetch.index;
        wr_o.beat        = cnt_q[BEAT_W:1];
        wr_o.data        = {mem_data_i, lo_q};
        wr_o.entry.tag   = req_i.pc.fetch.tag;
        wr_o.entry.valid = 1'b1;
        case (state_q)
            S_IDLE: begin
                if (need_refill || need_unc) begin
                    stall_o          = 1'b1;
                    mem_addr_valid_o = 1'b1;
                    if (mem_resp_ready_i) begin
                        state_d = need_refill ? S_MISS_DATA : S_UNC_DATA;
                    end else begin
                        state_d = need_refill ? S_MISS_REQ : S_UNC_REQ;
                    end
                end
                // index invalidate, ops 2 and 3 only get acked
                if (cacop_done_o && !cacop_op_i[1]) begin
                    wr_o.tag_we = `ICACHE_WAYS'(1) << cacop_addr.maint.way;
                    wr_o.index  = cacop_addr.maint.index;
                    wr_o.entry  = '0;
                end
            end
            S_MISS_REQ: begin
                stall_o          = 1'b1;
                mem_addr_valid_o = 1'b1;
                if (mem_resp_ready_i) begin
                    state_d = S_MISS_DATA;
                end
            end
            S_MISS_DATA: begin
                stall_o = 1'b1;
                // odd word completes a beat
                if (mem_data_valid_i && cnt_q[0]) begin
                    wr_o.data_we = way_oh;
                    if (last_word) begin
                        wr_o.tag_we = way_oh;
                        state_d     = S_REPLAY;
                    end
                end
            end
            S_REPLAY: begin
                stall_o = 1'b1;
                state_d = S_IDLE;
            end
            S_UNC_REQ: begin
                stall_o          = 1'b1;
                mem_addr_valid_o = 1'b1;
                if (mem_resp_ready_i) begin
                    state_d = S_UNC_DATA;
                end
            end
            S_UNC_DATA: begin
                if (unc_full) begin
                    unc_done_o = 1'b1;
                    if (inst_ready_i) begin
                        state_d = S_IDLE;
                    end
                end else begin
                    stall_o = 1'b1;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            repl_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == S_IDLE) begin
                cnt_q <= '0;
            end else if (mem_data_valid_i && (state_q == S_MISS_DATA ||
                         (state_q == S_UNC_DATA && !unc_full))) begin
                cnt_q <= cnt_q + 4'd1;
            end
            // flip the victim way once the block is in
            if (state_q == S_MISS_DATA && mem_data_valid_i && last_word) begin
                repl_q[req_i.pc.fetch.index] <= ~repl_q[req_i.pc.fetch.index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_MISS_DATA && mem_data_valid_i && !cnt_q[0]) begin
            lo_q <= mem_data_i;
        end
        if (state_q == S_IDLE) begin
            unc_q <= '0;
        end else if (state_q == S_UNC_DATA && mem_data_valid_i && !unc_full) begin
            unc_q[unc_lane] <= mem_data_i;
        end
    end

endmodule

`default_nettype wire

// File: src/fetch_result.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module fetch_result (
    input  icache_pkg::fetch_req_t                    req_i,
    input  logic                                      req_valid_i,
    input  icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0] tags_i,
    input  logic [`ICACHE_WAYS-1:0][63:0]             beats_i,
    input  logic                                      stall_i,
    input  logic [63:0]                               unc_data_i,
    input  logic                                      unc_done_i,
    output logic                                      hit_o,
    output logic                                      inst_valid_o,
    output icache_pkg::inst_pkt_t                     inst_pkt_o
);

    import icache_pkg::*;

    logic [`ICACHE_WAYS-1:0] way_hit;
    logic [63:0]             hit_data;
    logic                    has_lanes;
    logic                    cached_ok;

    // at most one way matches, so OR-ing is the way mux
    always_comb begin
        hit_data = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = tags_i[w].valid && (tags_i[w].tag == req_i.pc.fetch.tag);
            if (way_hit[w]) begin
                hit_data = hit_data | beats_i[w];
            end
        end
    end

    assign hit_o = |way_hit;

    assign has_lanes    = req_valid_i && |req_i.mask;
    assign cached_ok    = !req_i.uncached && !req_i.misaligned && hit_o && !stall_i;
    assign inst_valid_o = has_lanes && (cached_ok || unc_done_i || req_i.misaligned);

    always_comb begin
        inst_pkt_o.pc    = {req_i.pc[31:3], 3'b000};
        inst_pkt_o.mask  = req_i.mask;
        inst_pkt_o.exc   = req_i.misaligned;
        inst_pkt_o.ecode = req_i.misaligned ? `ICACHE_ECODE_ADEF : 6'd0;
        if (req_i.misaligned) begin
            inst_pkt_o.insts = '0;
        end else if (req_i.uncached) begin
            inst_pkt_o.insts = unc_data_i;
        end else begin
            inst_pkt_o.insts = hit_data;
        end
    end

endmodule

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid_i,
    input  logic [31:0]           fetch_pc_i,
    input  logic [1:0]            fetch_mask_i,
    output logic                  fetch_ready_o,
    output logic                  inst_valid_o,
    output icache_pkg::inst_pkt_t inst_pkt_o,
    input  logic                  inst_ready_i,
    input  logic                  cacop_valid_i,
    input  logic [1:0]            cacop_op_i,
    input  logic [31:0]           cacop_addr_i,
    output logic                  cacop_ready_o,
    output logic                  cacop_done_o,
    output logic                  mem_addr_valid_o,
    output logic [31:0]           mem_addr_o,
    output logic [7:0]            mem_len_o,
    input  logic                  mem_resp_ready_i,
    input  logic                  mem_data_valid_i,
    input  logic [31:0]           mem_data_i
);

    import icache_pkg::*;

    fetch_req_t                    req;
    logic                          req_valid;
    logic [INDEX_W-1:0]            rd_index;
    logic                          stall;
    logic                          hit;
    array_wr_t                     wr;
    logic [63:0]                   unc_data;
    logic                          unc_done;
    tag_entry_t [`ICACHE_WAYS-1:0] tags;
    logic [`ICACHE_WAYS-1:0][63:0] beats;

    fetch_decode u_fetch_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_mask_i  (fetch_mask_i),
        .inst_ready_i  (inst_ready_i),
        .stall_i       (stall),
        .fetch_ready_o (fetch_ready_o),
        .req_o         (req),
        .rd_index_o    (rd_index),
        .req_valid_o   (req_valid)
    );

    cache_ways u_cache_ways (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_i (rd_index),
        .rd_beat_i  (req.pc.fetch.beat),
        .wr_i       (wr),
        .tags_o     (tags),
        .beats_o    (beats)
    );

    refill_ctrl u_refill_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_i            (req),
        .req_valid_i      (req_valid),
        .hit_i            (hit),
        .inst_ready_i     (inst_ready_i),
        .cacop_valid_i    (cacop_valid_i),
        .cacop_op_i       (cacop_op_i),
        .cacop_addr_i     (cacop_addr_i),
        .mem_resp_ready_i (mem_resp_ready_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .stall_o          (stall),
        .wr_o             (wr),
        .unc_data_o       (unc_data),
        .unc_done_o       (unc_done),
        .cacop_ready_o    (cacop_ready_o),
        .cacop_done_o     (cacop_done_o),
        .mem_addr_valid_o (mem_addr_valid_o),
        .mem_addr_o       (mem_addr_o),
        .mem_len_o        (mem_len_o)
    );

    fetch_result u_fetch_result (
        .req_i        (req),
        .req_valid_i  (req_valid),
        .tags_i       (tags),
        .beats_i      (beats),
        .stall_i      (stall),
        .unc_data_i   (unc_data),
        .unc_done_i   (unc_done),
        .hit_o        (hit),
        .inst_valid_o (inst_valid_o),
        .inst_pkt_o   (inst_pkt_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'h7123_778b
) (
    input  logic        clk,
    input  logic        addr_valid_i,
    input  logic [31:0] addr_i,
    input  logic [7:0]  len_i,
    output logic        resp_ready_o,
    output logic        data_valid_o,
    output logic [31:0] data_o,
    output int          req_count_o,
    output logic [31:0] last_addr_o,
    output logic [7:0]  last_len_o
);

    logic [31:0] lcg_q;

    function automatic logic [31:0] lcg_draw();
        lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
        return {16'd0, lcg_q[31:16]};
    endfunction

    // memory contents follow the address
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return {a[15:0], ~a[15:0]};
    endfunction

    initial begin
        int unsigned gap;
        logic [31:0] base;
        logic [7:0]  len;
        lcg_q        = SEED;
        resp_ready_o = 1'b0;
        data_valid_o = 1'b0;
        data_o       = 32'd0;
        req_count_o  = 0;
        last_addr_o  = 32'd0;
        last_len_o   = 8'd0;
        forever begin
            @(negedge clk);
            if (addr_valid_i) begin
                base        = addr_i;
                len         = len_i;
                req_count_o = req_count_o + 1;
                last_addr_o = base;
                last_len_o  = len;
                // random accept delay, then one cycle of resp_ready
                gap = lcg_draw() % 4;
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #2;
                resp_ready_o = 1'b1;
                @(posedge clk);
                #2;
                resp_ready_o = 1'b0;
                for (int i = 0; i < int'(len); i++) begin
                    gap = lcg_draw() % 3;
                    repeat (gap) begin
                        @(posedge clk);
                        #2;
                    end
                    data_valid_o = 1'b1;
                    data_o       = word_at(base + 32'(4 * i));
                    @(posedge clk);
                    #2;
                    data_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_icache.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module tb_icache;

    import icache_pkg::*;

    localparam int   NUM_ROWS    = 26;
    localparam int   CYCLE_LIMIT = NUM_ROWS * 40;
    localparam logic FETCH       = 1'b0;
    localparam logic CACOP       = 1'b1;

    // mask holds the op code on cacop rows
    typedef struct packed {
        logic        kind;
        logic [31:0] addr;
        logic [1:0]  mask;
        logic [1:0]  bus_reqs;
    } row_t;

    row_t rows [NUM_ROWS] = '{
        // cold miss then hits in the same block
        '{FETCH, 32'h0000_1040, 2'b11, 2'd1},
        '{FETCH, 32'h0000_1048, 2'b11, 2'd0},
        '{FETCH, 32'h0000_1054, 2'b10, 2'd0},
        '{FETCH, 32'h0000_105C, 2'b01, 2'd0},
        // uncached region is never allocated
        '{FETCH, 32'hA000_0100, 2'b11, 2'd1},
        '{FETCH, 32'hA000_0100, 2'b11, 2'd1},
        '{FETCH, 32'hA000_0208, 2'b10, 2'd1},
        '{FETCH, 32'hA000_0310, 2'b01, 2'd1},
        // three tags on set 3
        '{FETCH, 32'h0000_3060, 2'b11, 2'd1},
        '{FETCH, 32'h0000_5060, 2'b11, 2'd1},
        '{FETCH, 32'h0001_7068, 2'b11, 2'd1},
        '{FETCH, 32'h0000_5070, 2'b11, 2'd0},
        '{FETCH, 32'h0000_3060, 2'b11, 2'd1},
        '{FETCH, 32'h0001_7060, 2'b11, 2'd0},
        // invalidate way 0 of set 3
        '{CACOP, 32'h0000_0060, 2'd0, 2'd0},
        '{FETCH, 32'h0001_7068, 2'b11, 2'd1},
        '{FETCH, 32'h0000_3068, 2'b11, 2'd0},
        // op 2 is acked only
        '{CACOP, 32'h0000_0061, 2'd2, 2'd0},
        '{FETCH, 32'h0000_3078, 2'b11, 2'd0},
        '{CACOP, 32'h0000_0040, 2'd1, 2'd0},
        '{FETCH, 32'h0000_1040, 2'b11, 2'd1},
        // misaligned pcs
        '{FETCH, 32'h0000_1042, 2'b11, 2'd0},
        '{FETCH, 32'hA000_0101, 2'b01, 2'd0},
        '{FETCH, 32'h0000_1048, 2'b11, 2'd0},
        '{FETCH, 32'hFFFF_FFE0, 2'b11, 2'd1},
        '{FETCH, 32'hFFFF_FFF8, 2'b01, 2'd0}
    };

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic [1:0]  fetch_mask;
    logic        fetch_ready;
    logic        inst_valid;
    inst_pkt_t   inst_pkt;
    logic        inst_ready;
    logic        cacop_valid;
    logic [1:0]  cacop_op;
    logic [31:0] cacop_addr;
    logic        cacop_ready;
    logic        cacop_done;
    logic        mem_addr_valid;
    logic [31:0] mem_addr;
    logic [7:0]  mem_len;
    logic        mem_resp_ready;
    logic        mem_data_valid;
    logic [31:0] mem_data;
    int          mem_reqs;
    logic [31:0] mem_last_addr;
    logic [7:0]  mem_last_len;
    logic [31:0] lcg;
    int          errors;
    int          packets;
    int          cycles;

    icache_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_valid_i    (fetch_valid),
        .fetch_pc_i       (fetch_pc),
        .fetch_mask_i     (fetch_mask),
        .fetch_ready_o    (fetch_ready),
        .inst_valid_o     (inst_valid),
        .inst_pkt_o       (inst_pkt),
        .inst_ready_i     (inst_ready),
        .cacop_valid_i    (cacop_valid),
        .cacop_op_i       (cacop_op),
        .cacop_addr_i     (cacop_addr),
        .cacop_ready_o    (cacop_ready),
        .cacop_done_o     (cacop_done),
        .mem_addr_valid_o (mem_addr_valid),
        .mem_addr_o       (mem_addr),
        .mem_len_o        (mem_len),
        .mem_resp_ready_i (mem_resp_ready),
        .mem_data_valid_i (mem_data_valid),
        .mem_data_i       (mem_data)
    );

    tb_mem_model #(
        .SEED (32'h7123_778b)
    ) u_mem (
        .clk          (clk),
        .addr_valid_i (mem_addr_valid),
        .addr_i       (mem_addr),
        .len_i        (mem_len),
        .resp_ready_o (mem_resp_ready),
        .data_valid_o (mem_data_valid),
        .data_o       (mem_data),
        .req_count_o  (mem_reqs),
        .last_addr_o  (mem_last_addr),
        .last_len_o   (mem_last_len)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // decode-side handshakes as the DUT makes them
    initial begin
        packets = 0;
        forever begin
            @(negedge clk);
            if (rst_n && inst_valid && inst_ready) begin
                packets++;
            end
        end
    end

    function automatic logic [31:0] draw();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return {16'd0, lcg[31:16]};
    endfunction

    function automatic logic [31:0] mem_rule(input logic [31:0] a);
        return {a[15:0], ~a[15:0]};
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("ERR t=%0t %s got %0h exp %0h", $time, name, got, exp);
    endtask

    task automatic check_packet(input row_t row);
        logic [31:0] al;
        logic [63:0] exp_insts;
        logic        bad_pc;
        logic        unc;
        al     = {row.addr[31:3], 3'b000};
        bad_pc = (row.addr[1:0] != 2'b00);
        unc    = (row.addr[31:28] == `ICACHE_UNCACHED_BASE);
        if (bad_pc) begin
            exp_insts = '0;
        end else if (unc) begin
            exp_insts = {row.mask[1] ? mem_rule(al + 32'd4) : 32'd0,
                         row.mask[0] ? mem_rule(al) : 32'd0};
        end else begin
            exp_insts = {mem_rule(al + 32'd4), mem_rule(al)};
        end
        if (inst_pkt.pc !== al) begin
            report_mismatch("inst_pkt_o.pc", 128'(inst_pkt.pc), 128'(al));
        end
        if (inst_pkt.mask !== row.mask) begin
            report_mismatch("inst_pkt_o.mask", 128'(inst_pkt.mask), 128'(row.mask));
        end
        if (inst_pkt.insts !== exp_insts) begin
            report_mismatch("inst_pkt_o.insts", 128'(inst_pkt.insts), 128'(exp_insts));
        end
        if (inst_pkt.exc !== bad_pc) begin
            report_mismatch("inst_pkt_o.exc", 128'(inst_pkt.exc), 128'(bad_pc));
        end
        if (inst_pkt.ecode !== (bad_pc ? `ICACHE_ECODE_ADEF : 6'd0)) begin
            report_mismatch("inst_pkt_o.ecode", 128'(inst_pkt.ecode),
                            128'(bad_pc ? `ICACHE_ECODE_ADEF : 6'd0));
        end
    endtask

    task automatic check_bus(input row_t row);
        logic [31:0] exp_addr;
        logic [7:0]  exp_len;
        if (row.addr[31:28] == `ICACHE_UNCACHED_BASE) begin
            exp_addr = {row.addr[31:3], 3'b000} + ((row.mask == 2'b10) ? 32'd4 : 32'd0);
            exp_len  = (row.mask == 2'b11) ? 8'd2 : 8'd1;
        end else begin
            // 8 words of 4 bytes
            exp_addr = {row.addr[31:5], 5'b00000};
            exp_len  = 8'(`ICACHE_BLOCK_WORDS);
        end
        if (mem_last_addr !== exp_addr) begin
            report_mismatch("mem_addr_o", 128'(mem_last_addr), 128'(exp_addr));
        end
        if (mem_last_len !== exp_len) begin
            report_mismatch("mem_len_o", 128'(mem_last_len), 128'(exp_len));
        end
    endtask

    task automatic apply_fetch(input row_t row);
        inst_pkt_t held_pkt;
        logic      held;
        logic      taken;
        held        = 1'b0;
        taken       = 1'b0;
        fetch_valid = 1'b1;
        fetch_pc    = row.addr;
        fetch_mask  = row.mask;
        @(negedge clk);
        if (inst_valid) begin
            errors++;
            $display("extra packet seen at %0t before pc %h was sent", $time, row.addr);
        end
        while (!fetch_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        fetch_valid = 1'b0;
        // decode side takes the packet on random cycles
        while (!taken) begin
            inst_ready = (draw() % 4) != 0;
            @(negedge clk);
            if (inst_valid) begin
                if (held && inst_pkt !== held_pkt) begin
                    report_mismatch("inst_pkt_o", 128'(inst_pkt), 128'(held_pkt));
                end
                if (inst_ready) begin
                    taken = 1'b1;
                    check_packet(row);
                end else begin
                    held     = 1'b1;
                    held_pkt = inst_pkt;
                end
            end else if (held) begin
                errors++;
                $display("packet for pc %h dropped at %0t before it was taken", row.addr, $time);
            end
            @(posedge clk);
            #2;
        end
    endtask

    task automatic issue_cacop(input row_t row);
        cacop_valid = 1'b1;
        cacop_op    = row.mask;
        cacop_addr  = row.addr;
        @(negedge clk);
        while (!cacop_ready) begin
            @(negedge clk);
        end
        if (cacop_done !== 1'b1) begin
            report_mismatch("cacop_done_o", 128'(cacop_done), 128'd1);
        end
        @(posedge clk);
        #2;
        cacop_valid = 1'b0;
        @(negedge clk);
        if (cacop_done !== 1'b0) begin
            report_mismatch("cacop_done_o", 128'(cacop_done), 128'd0);
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        int start_reqs;
        int fetch_rows;
        errors      = 0;
        fetch_rows  = 0;
        lcg         = 32'h7123_778b;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = 32'd0;
        fetch_mask  = 2'b00;
        inst_ready  = 1'b0;
        cacop_valid = 1'b0;
        cacop_op    = 2'd0;
        cacop_addr  = 32'd0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (fetch_ready !== 1'b1) begin
            report_mismatch("fetch_ready_o", 128'(fetch_ready), 128'd1);
        end
        if (inst_valid !== 1'b0) begin
            report_mismatch("inst_valid_o", 128'(inst_valid), 128'd0);
        end
        if (mem_addr_valid !== 1'b0) begin
            report_mismatch("mem_addr_valid_o", 128'(mem_addr_valid), 128'd0);
        end
        if (cacop_ready !== 1'b1) begin
            report_mismatch("cacop_ready_o", 128'(cacop_ready), 128'd1);
        end
        if (cacop_done !== 1'b0) begin
            report_mismatch("cacop_done_o", 128'(cacop_done), 128'd0);
        end
        @(posedge clk);
        #2;
        for (int r = 0; r < NUM_ROWS; r++) begin
            start_reqs = mem_reqs;
            if (rows[r].kind == CACOP) begin
                issue_cacop(rows[r]);
            end else begin
                fetch_rows++;
                apply_fetch(rows[r]);
            end
            if (mem_reqs - start_reqs != int'(rows[r].bus_reqs)) begin
                errors++;
                $display("row %0d made %0d bus requests where %0d were expected",
                         r, mem_reqs - start_reqs, rows[r].bus_reqs);
            end else if (rows[r].bus_reqs != 2'd0) begin
                check_bus(rows[r]);
            end
        end
        @(negedge clk);
        if (inst_valid !== 1'b0) begin
            report_mismatch("inst_valid_o", 128'(inst_valid), 128'd0);
        end
        if (packets != fetch_rows) begin
            errors++;
            $display("%0d packets taken for %0d fetches", packets, fetch_rows);
        end
        $display("rows %0d, packets %0d of %0d, errors %0d", NUM_ROWS, packets, fetch_rows,
                 errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d packets, %0d errors", cycles, packets, errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/icache_pkg.sv
src/fetch_decode.sv
src/cache_ways.sv
src/refill_ctrl.sv
src/fetch_result.sv
src/icache_top.sv
tests/tb_mem_model.sv
tests/tb_icache.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module tb_icache -f list.f &&
./obj_dir/Vtb_icache | tee /dev/stderr | grep -q "TESTS PASSED" && exit 0 || exit 1
